//--- filelist.f
src/rv32m_pkg.sv
src/rv32m_decode.sv
src/shift_add_multiplier.sv
src/shift_test_restore_divider.sv
src/rv32m_execute.sv
testbench/clock_gen.sv
testbench/rv32m_tb.sv

//--- run_sim.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module rv32m_tb -f filelist.f -o rv32m_sim
./obj_dir/rv32m_sim | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- testbench/rv32m_tb.sv
`timescale 1ns/1ps

module rv32m_tb;
  import rv32m_pkg::*;

  localparam int  WIDTH       = 32;
  localparam real PERIOD      = 4.0;
  localparam real DRIVE_DELAY = 1.0;
  localparam int  OP_LIMIT    = WIDTH + 8;  // cycles allowed per operation
  localparam int  OP_COUNT    = 300;        // directed and random operations, rounded up
  localparam real WATCHDOG_NS = (OP_COUNT * (WIDTH + 10) + 200) * PERIOD;
  localparam logic [WIDTH-1:0] MIN_VAL = {1'b1, {(WIDTH-1){1'b0}}};
  localparam logic [WIDTH-1:0] MAX_VAL = {1'b0, {(WIDTH-1){1'b1}}};

  logic             CLK;
  logic             nRST;
  logic             start;
  logic [2:0]       funct3;
  logic [WIDTH-1:0] rs1_data;
  logic [WIDTH-1:0] rs2_data;
  logic             busy;
  logic [WIDTH-1:0] result;
  integer           seed;
  int               ops;
  int               mismatches;
  int               timeouts;
  int               other_errs;

  clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(4)) clk_i (.CLK(CLK), .nRST(nRST));

  rv32m_execute #(.WIDTH(WIDTH)) UUT (
    .CLK      (CLK),
    .nRST     (nRST),
    .start    (start),
    .funct3   (funct3),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .busy     (busy),
    .result   (result)
  );

  // RV32M reference, products taken exactly in 2*WIDTH bits
  function automatic logic [WIDTH-1:0] model_result(input logic [2:0] fn,
      input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
    logic [2*WIDTH-1:0]      a_ext;
    logic [2*WIDTH-1:0]      b_ext;
    logic [2*WIDTH-1:0]      prod;
    logic signed [WIDTH-1:0] sa;
    logic signed [WIDTH-1:0] sb;
    logic                    ovf;
    a_ext = (fn == FN_MULH || fn == FN_MULHSU) ? {{WIDTH{a[WIDTH-1]}}, a} : {{WIDTH{1'b0}}, a};
    b_ext = (fn == FN_MULH) ? {{WIDTH{b[WIDTH-1]}}, b} : {{WIDTH{1'b0}}, b};
    prod  = a_ext * b_ext;
    sa    = a;
    sb    = b;
    ovf   = (a == MIN_VAL) && (b == '1);
    case (fn)
      FN_MUL: return prod[WIDTH-1:0];
      FN_DIV: begin
        if (b == '0) begin
          return '1;
        end else if (ovf) begin
          return MIN_VAL;
        end
        return sa / sb; // truncates toward zero
      end
      FN_DIVU: return (b == '0) ? '1 : a / b;
      FN_REM: begin
        if (b == '0) begin
          return a;
        end else if (ovf) begin
          return '0;
        end
        return sa % sb; // sign of the dividend
      end
      FN_REMU: return (b == '0) ? a : a % b;
      default: return prod[2*WIDTH-1:WIDTH]; // MULH, MULHSU, MULHU
    endcase
  endfunction

  // one request, waits for busy low, cycles counts sampled busy-high cycles
  task automatic run_op(input logic [2:0] fn, input logic [WIDTH-1:0] a,
      input logic [WIDTH-1:0] b, output int cycles);
    logic [WIDTH-1:0] expected;
    expected = model_result(fn, a, b);
    @(posedge CLK);
    #(DRIVE_DELAY);
    start    = 1'b1;
    funct3   = fn;
    rs1_data = a;
    rs2_data = b;
    cycles   = 0;
    @(negedge CLK);
    while (busy && cycles < OP_LIMIT) begin
      cycles++;
      @(negedge CLK);
    end
    ops++;
    assert (!busy) else begin
      timeouts++;
      $display("%0t: funct3=%0d a=%h b=%h still busy after %0d cycles",
               $time, fn, a, b, OP_LIMIT);
    end
    if (!busy) begin
      assert (result == expected) else begin
        mismatches++;
        $display("Mismatch at %0t: funct3=%0d a=%h b=%h expected %h got %h",
                 $time, fn, a, b, expected, result);
      end
    end
  endtask

  task automatic op_group(input logic [2:0] base, input logic [WIDTH-1:0] a,
      input logic [WIDTH-1:0] b);
    int cycles;
    for (int k = 0; k < 4; k++) begin
      run_op(base + 3'(k), a, b, cycles);
    end
  endtask

  task automatic multiply_tests();
    op_group(FN_MUL, WIDTH'(3), WIDTH'(5));
    op_group(FN_MUL, WIDTH'(-3), WIDTH'(5));
    op_group(FN_MUL, WIDTH'(3), WIDTH'(-5));
    op_group(FN_MUL, WIDTH'(-3), WIDTH'(-5));
    op_group(FN_MUL, '0, MIN_VAL);
    op_group(FN_MUL, MIN_VAL, MIN_VAL);
    op_group(FN_MUL, MAX_VAL, MAX_VAL);
    op_group(FN_MUL, MIN_VAL, '1);
    op_group(FN_MUL, '1, '1);
  endtask

  task automatic divide_tests();
    op_group(FN_DIV, WIDTH'(20), WIDTH'(6));
    op_group(FN_DIV, WIDTH'(-20), WIDTH'(6));
    op_group(FN_DIV, WIDTH'(20), WIDTH'(-6));
    op_group(FN_DIV, WIDTH'(-20), WIDTH'(-6));
    op_group(FN_DIV, WIDTH'(7), WIDTH'(7));
    op_group(FN_DIV, '0, WIDTH'(5));
    op_group(FN_DIV, MIN_VAL, WIDTH'(3));
    op_group(FN_DIV, MAX_VAL, '1);
    op_group(FN_DIV, WIDTH'(1), MIN_VAL);
  endtask

  // zero divisors and MIN/-1 are answered in the request cycle
  task automatic special_case_tests();
    int cycles;
    for (int k = 0; k < 10; k++) begin
      if (k < 8) begin
        run_op(FN_DIV + 3'(k % 4), (k < 4) ? WIDTH'(12345) : WIDTH'(-77), '0, cycles);
      end else begin
        run_op((k == 8) ? FN_DIV : FN_REM, MIN_VAL, '1, cycles);
      end
      assert (cycles == 0) else begin
        other_errs++;
        $display("%0t: busy was high for a special divide case (step %0d)", $time, k);
      end
    end
  endtask

  task automatic hold_and_change(input logic [2:0] fn, input logic [WIDTH-1:0] a,
      input logic [WIDTH-1:0] b);
    int               cycles;
    logic [WIDTH-1:0] held;
    run_op(fn, a, b, cycles);
    held = model_result(fn, a, b);
    repeat (6) begin
      @(negedge CLK);
      assert (!busy) else begin
        other_errs++;
        $display("%0t: busy rose although the request was unchanged", $time);
      end
      assert (result == held) else begin
        mismatches++;
        $display("Mismatch at %0t: held result expected %h got %h", $time, held, result);
      end
    end
    run_op(fn, a, b + 1'b1, cycles);
    assert (cycles > 0) else begin
      other_errs++;
      $display("%0t: busy did not rise after an operand change", $time);
    end
  endtask

  task automatic random_tests();
    int               cycles;
    logic [2:0]       fn;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    for (int i = 0; i < 200; i++) begin
      fn = 3'($random(seed));
      a  = WIDTH'($random(seed));
      b  = WIDTH'($random(seed));
      if (i % 25 == 0) begin
        b = '0;
      end
      run_op(fn, a, b, cycles);
    end
  endtask

  initial begin
    seed       = 32'h7bad6a96;
    start      = 1'b0;
    funct3     = '0;
    rs1_data   = '0;
    rs2_data   = '0;
    ops        = 0;
    mismatches = 0;
    timeouts   = 0;
    other_errs = 0;
    wait (nRST === 1'b1);
    multiply_tests();
    divide_tests();
    special_case_tests();
    hold_and_change(FN_MULH, WIDTH'(-1234567), WIDTH'(7654321));
    hold_and_change(FN_REM, WIDTH'(-1000), WIDTH'(33));
    random_tests();
    $display("summary: %0d operations, %0d mismatches, %0d timeouts, %0d other errors",
             ops, mismatches, timeouts, other_errs);
    if (mismatches + timeouts + other_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired at %0t before the tests completed", $time);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- testbench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
  parameter real PERIOD       = 4.0,
  parameter int  RESET_CYCLES = 4
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever begin
      #(PERIOD / 2.0);
      CLK = ~CLK;
    end
  end

  // release away from the rising edge
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    nRST = 1'b1;
  end

endmodule

//--- src/rv32m_execute.sv
`timescale 1ns/1ps

module rv32m_execute #(
  parameter int WIDTH = rv32m_pkg::WORD_SIZE
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             start,
  input  logic [2:0]       funct3,
  input  logic [WIDTH-1:0] rs1_data,
  input  logic [WIDTH-1:0] rs2_data,
  output logic             busy,
  output logic [WIDTH-1:0] result
);
  import rv32m_pkg::*;

  localparam logic [WIDTH-1:0] MIN_INT = {1'b1, {(WIDTH-1){1'b0}}};

  logic [2:0]         op_curr;
  logic [2:0]         op_save;
  logic [2:0]         operation;
  logic [1:0]         sign_curr;
  logic [1:0]         sign_save;
  logic [1:0]         sign_mode;
  logic               lower_word;
  logic [WIDTH-1:0]   op_a_save;
  logic [WIDTH-1:0]   op_b_save;
  logic [WIDTH-1:0]   op_a;
  logic [WIDTH-1:0]   op_b;
  logic               operand_diff;
  logic               is_div;
  logic               div_zero;
  logic               overflow;
  logic               special;
  logic               mul_start;
  logic               div_start;
  logic [2*WIDTH-1:0] product;
  logic               mul_finished;
  logic [WIDTH-1:0]   quotient;
  logic [WIDTH-1:0]   remainder;
  logic               div_finished;
  logic               sel_finished;

  rv32m_decode dec_i (
    .funct3     (funct3),
    .op_sel     (op_curr),
    .sign_mode  (sign_curr),
    .lower_word (lower_word)
  );

  // new request when anything differs from the saved copy
  assign operand_diff = start && (rs1_data != op_a_save || rs2_data != op_b_save ||
                                  sign_curr != sign_save || op_curr != op_save);
  assign op_a      = operand_diff ? rs1_data : op_a_save;
  assign op_b      = operand_diff ? rs2_data : op_b_save;
  assign sign_mode = operand_diff ? sign_curr : sign_save;
  assign operation = operand_diff ? op_curr : op_save;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      op_a_save <= '0;
      op_b_save <= '0;
      sign_save <= '0;
      op_save   <= '0;
    end else if (operand_diff) begin
      op_a_save <= rs1_data;
      op_b_save <= rs2_data;
      sign_save <= sign_curr;
      op_save   <= op_curr;
    end
  end

  // special divide cases are answered here, divider stays idle
  assign is_div    = operation == OP_DIV || operation == OP_REM;
  assign div_zero  = op_b == '0;
  assign overflow  = sign_mode == SIGN_SS && op_a == MIN_INT && op_b == '1;
  assign special   = is_div && (div_zero || overflow);
  assign mul_start = operand_diff && operation == OP_MUL;
  assign div_start = operand_diff && is_div && !special;

  shift_add_multiplier #(.N(WIDTH)) mult_i (
    .CLK          (CLK),
    .nRST         (nRST),
    .start        (mul_start),
    .multiplicand (op_a),
    .multiplier   (op_b),
    .is_signed    (sign_mode),
    .product      (product),
    .finished     (mul_finished)
  );

  shift_test_restore_divider #(.N(WIDTH)) div_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .start     (div_start),
    .is_signed (sign_mode == SIGN_SS),
    .dividend  (op_a),
    .divisor   (op_b),
    .quotient  (quotient),
    .remainder (remainder),
    .finished  (div_finished)
  );

  always_comb begin
    busy   = 1'b0;
    result = '0; // nothing requested since reset
    case (operation)
      OP_MUL: begin
        busy   = mul_start || !mul_finished;
        result = lower_word ? product[WIDTH-1:0] : product[2*WIDTH-1:WIDTH];
      end
      OP_DIV: begin
        busy = (div_start || !div_finished) && !special;
        if (div_zero) begin
          result = '1;
        end else if (overflow) begin
          result = MIN_INT;
        end else begin
          result = quotient;
        end
      end
      OP_REM: begin
        busy = (div_start || !div_finished) && !special;
        if (div_zero) begin
          result = op_a;
        end else if (overflow) begin
          result = '0;
        end else begin
          result = remainder;
        end
      end
      default: begin
        busy = 1'b0;
      end
    endcase
  end

  assign sel_finished = (operation == OP_MUL) ? mul_finished : div_finished;

  result_known: assert property (@(posedge CLK) disable iff (!nRST)
    !busy |-> !$isunknown(result));

  // busy falls together with the unit's finished edge, or for a special divide
  busy_fall_reason: assert property (@(posedge CLK) disable iff (!nRST)
    $fell(busy) |-> special || $rose(sel_finished));

endmodule

//--- src/shift_test_restore_divider.sv
`timescale 1ns/1ps

module shift_test_restore_divider #(
  parameter int N = 32
) (
  input  logic         CLK,
  input  logic         nRST,
  input  logic         start,
  input  logic         is_signed,
  input  logic [N-1:0] dividend,
  input  logic [N-1:0] divisor,
  output logic [N-1:0] quotient,
  output logic [N-1:0] remainder,
  output logic         finished
);

  localparam int CW = $clog2(N + 1);

  logic          dvd_neg;
  logic          dvs_neg;
  logic [N-1:0]  dvd_mag;
  logic [N-1:0]  dvs_mag;
  logic [N-1:0]  shreg;      // dividend bits leave at the top, quotient bits enter below
  logic [N-1:0]  dvs;
  logic [N-1:0]  prem;       // partial remainder
  logic [N:0]    prem_shift;
  logic [N+1:0]  trial;
  logic          q_neg;
  logic          r_neg;
  logic          running;
  logic [CW-1:0] count;

  assign dvd_neg = is_signed && dividend[N-1];
  assign dvs_neg = is_signed && divisor[N-1];
  assign dvd_mag = dvd_neg ? -dividend : dividend;
  assign dvs_mag = dvs_neg ? -divisor : divisor;

  // next dividend bit into the partial remainder, then trial subtract
  assign prem_shift = {prem, shreg[N-1]};
  assign trial      = {1'b0, prem_shift} - {2'b00, dvs};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      running  <= 1'b0;
      count    <= '0;
      finished <= 1'b1;
    end else if (start) begin
      running  <= 1'b1;
      count    <= '0;
      finished <= 1'b0;
    end else if (running) begin
      if (count == CW'(N)) begin
        running  <= 1'b0;
        finished <= 1'b1;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      shreg <= dvd_mag;
      dvs   <= dvs_mag;
      prem  <= '0;
      q_neg <= dvd_neg ^ dvs_neg;
      r_neg <= dvd_neg; // remainder follows the dividend
    end else if (running) begin
      if (count == CW'(N)) begin
        quotient  <= q_neg ? -shreg : shreg;
        remainder <= r_neg ? -prem : prem;
      end else if (trial[N+1]) begin
        prem  <= prem_shift[N-1:0]; // negative, restore
        shreg <= {shreg[N-2:0], 1'b0};
      end else begin
        prem  <= trial[N-1:0];
        shreg <= {shreg[N-2:0], 1'b1};
      end
    end
  end

  // the execute stage answers zero divisors itself
  no_zero_divisor: assert property (@(posedge CLK) disable iff (!nRST)
    start |-> divisor != '0);

endmodule

//--- src/shift_add_multiplier.sv
`timescale 1ns/1ps

module shift_add_multiplier #(
  parameter int N = 32
) (
  input  logic           CLK,
  input  logic           nRST,
  input  logic           start,
  input  logic [N-1:0]   multiplicand,
  input  logic [N-1:0]   multiplier,
  input  logic [1:0]     is_signed,
  output logic [2*N-1:0] product,
  output logic           finished
);
  import rv32m_pkg::*;

  localparam int CW = $clog2(N + 1);

  logic           a_neg;
  logic           b_neg;
  logic [N-1:0]   a_mag;
  logic [N-1:0]   b_mag;
  logic [2*N-1:0] mcand;   // moves left one bit per step
  logic [N-1:0]   mplier;  // moves right one bit per step
  logic [2*N-1:0] acc;
  logic           negate;
  logic           running;
  logic [CW-1:0]  count;

  // operand a is signed in SU and SS, operand b only in SS
  assign a_neg = (is_signed == SIGN_SU || is_signed == SIGN_SS) && multiplicand[N-1];
  assign b_neg = (is_signed == SIGN_SS) && multiplier[N-1];
  assign a_mag = a_neg ? -multiplicand : multiplicand;
  assign b_mag = b_neg ? -multiplier : multiplier;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      running  <= 1'b0;
      count    <= '0;
      finished <= 1'b1; // idle
    end else if (start) begin
      running  <= 1'b1;
      count    <= '0;
      finished <= 1'b0;
    end else if (running) begin
      if (count == CW'(N)) begin
        running  <= 1'b0;
        finished <= 1'b1;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      mcand  <= {{N{1'b0}}, a_mag};
      mplier <= b_mag;
      acc    <= '0;
      negate <= a_neg ^ b_neg;
    end else if (running) begin
      if (count == CW'(N)) begin
        product <= negate ? -acc : acc; // sign cycle
      end else begin
        if (mplier[0]) begin
          acc <= acc + mcand;
        end
        mcand  <= mcand << 1;
        mplier <= mplier >> 1;
      end
    end
  end

  // no new start in the cycle where finished rises
  start_holds_off_finish: assert property (@(posedge CLK) disable iff (!nRST)
    start |-> !$rose(finished));

endmodule

//--- src/rv32m_decode.sv
`timescale 1ns/1ps

module rv32m_decode (
  input  logic [2:0] funct3,
  output logic [2:0] op_sel,
  output logic [1:0] sign_mode,
  output logic       lower_word
);
  import rv32m_pkg::*;

  always_comb begin
    op_sel     = OP_MUL;
    sign_mode  = SIGN_UU;
    lower_word = 1'b0;
    case (funct3)
      FN_MUL: begin
        lower_word = 1'b1; // low half is sign independent
      end
      FN_MULH: begin
        sign_mode = SIGN_SS;
      end
      FN_MULHSU: begin
        sign_mode = SIGN_SU;
      end
      FN_MULHU: begin
        sign_mode = SIGN_UU;
      end
      FN_DIV: begin
        op_sel    = OP_DIV;
        sign_mode = SIGN_SS;
      end
      FN_DIVU: begin
        op_sel = OP_DIV;
      end
      FN_REM: begin
        op_sel    = OP_REM;
        sign_mode = SIGN_SS;
      end
      FN_REMU: begin
        op_sel = OP_REM;
      end
      default: begin
        op_sel = OP_MUL;
      end
    endcase
  end

endmodule

//--- src/rv32m_pkg.sv
package rv32m_pkg;

  // default data width of the execute block
  parameter int WORD_SIZE = 32;

  // funct3 codes of the M extension (opcode OP, funct7 0000001)
  parameter logic [2:0] FN_MUL    = 3'b000;
  parameter logic [2:0] FN_MULH   = 3'b001;
  parameter logic [2:0] FN_MULHSU = 3'b010;
  parameter logic [2:0] FN_MULHU  = 3'b011;
  parameter logic [2:0] FN_DIV    = 3'b100;
  parameter logic [2:0] FN_DIVU   = 3'b101;
  parameter logic [2:0] FN_REM    = 3'b110;
  parameter logic [2:0] FN_REMU   = 3'b111;

  // signedness of {operand a, operand b}
  parameter logic [1:0] SIGN_UU = 2'b00;
  parameter logic [1:0] SIGN_SU = 2'b10;
  parameter logic [1:0] SIGN_SS = 2'b11;

  // one-hot unit select, also kept in the operand saver
  parameter logic [2:0] OP_MUL = 3'b100;
  parameter logic [2:0] OP_DIV = 3'b010;
  parameter logic [2:0] OP_REM = 3'b001;

endpackage
